//--- hdl/tcdm_pkg.sv
//----------------------------------------------------------------------
// Sizes of the two-group cluster. num_groups is fixed at two.
// Remote credits also size the receive FIFO and the response buffer.
//----------------------------------------------------------------------
package tcdm_pkg;

  localparam int unsigned num_groups   = 2;
  localparam int unsigned group_width  = $clog2(num_groups);
  localparam int unsigned row_width    = 6;
  localparam int unsigned data_width   = 32;
  localparam int unsigned tag_width    = 4;
  localparam int unsigned addr_width   = group_width + row_width;

  // End-to-end credits per group
  localparam int unsigned credits      = 4;
  localparam int unsigned credit_width = $clog2(credits + 1);
  localparam int unsigned ptr_width    = $clog2(credits);

  // One slot for every outstanding remote request
  localparam int unsigned resp_depth   = credits;

  // Requester word address, or its group and row fields
  typedef union packed {
    logic [addr_width-1:0] flat;
    struct packed {
      logic [group_width-1:0] group;
      logic [row_width-1:0]   row;
    } split;
  } tcdm_addr_u;

endpackage

//--- hdl/tcdm_router.sv
//----------------------------------------------------------------------
// Local requests pass through combinationally; remote ones are
// registered onto the link and need a credit, returned by the merger.
//----------------------------------------------------------------------
module tcdm_router (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             req_valid_i,
  input  logic                             req_we_i,
  input  tcdm_pkg::tcdm_addr_u             req_addr_i,
  input  logic [tcdm_pkg::data_width-1:0]  req_wdata_i,
  input  logic [tcdm_pkg::tag_width-1:0]   req_tag_i,
  input  logic [tcdm_pkg::group_width-1:0] group_id_i,
  input  logic                             credit_return_i,
  output logic                             req_ready_o,
  output logic                             lreq_valid_o,
  output logic                             lreq_we_o,
  output logic [tcdm_pkg::row_width-1:0]   lreq_row_o,
  output logic [tcdm_pkg::data_width-1:0]  lreq_wdata_o,
  output logic [tcdm_pkg::tag_width-1:0]   lreq_tag_o,
  output logic                             rreq_valid_o,
  output logic                             rreq_we_o,
  output logic [tcdm_pkg::row_width-1:0]   rreq_row_o,
  output logic [tcdm_pkg::data_width-1:0]  rreq_wdata_o,
  output logic [tcdm_pkg::tag_width-1:0]   rreq_tag_o
);

  logic                              is_local;
  logic                              has_credit;
  logic                              send;
  logic [tcdm_pkg::credit_width-1:0] credit_cnt;

  assign is_local    = (req_addr_i.split.group == group_id_i);
  assign has_credit  = (credit_cnt != '0);
  assign req_ready_o = is_local || has_credit;
  assign send        = req_valid_i && !is_local && has_credit;

  // Straight to the own bank
  assign lreq_valid_o = req_valid_i && is_local;
  assign lreq_we_o    = req_we_i;
  assign lreq_row_o   = req_addr_i.split.row;
  assign lreq_wdata_o = req_wdata_i;
  assign lreq_tag_o   = req_tag_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rreq_valid_o <= 1'b0;
      credit_cnt   <= tcdm_pkg::credits[tcdm_pkg::credit_width-1:0];
    end else begin
      rreq_valid_o <= send;
      // A send and a return in one cycle cancel out
      if (send && !credit_return_i) begin
        credit_cnt <= credit_cnt - 1'b1;
      end else if (!send && credit_return_i) begin
        credit_cnt <= credit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      rreq_we_o    <= req_we_i;
      rreq_row_o   <= req_addr_i.split.row;
      rreq_wdata_o <= req_wdata_i;
      rreq_tag_o   <= req_tag_i;
    end
  end

endmodule

//--- hdl/tcdm_link_rx.sv
//----------------------------------------------------------------------
// Receive FIFO with no ready; upstream credits keep it from overflow.
//----------------------------------------------------------------------
module tcdm_link_rx (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            rreq_valid_i,
  input  logic                            rreq_we_i,
  input  logic [tcdm_pkg::row_width-1:0]  rreq_row_i,
  input  logic [tcdm_pkg::data_width-1:0] rreq_wdata_i,
  input  logic [tcdm_pkg::tag_width-1:0]  rreq_tag_i,
  input  logic                            pop_i,
  output logic                            head_valid_o,
  output logic                            head_we_o,
  output logic [tcdm_pkg::row_width-1:0]  head_row_o,
  output logic [tcdm_pkg::data_width-1:0] head_wdata_o,
  output logic [tcdm_pkg::tag_width-1:0]  head_tag_o
);

  logic                              we_q    [tcdm_pkg::credits];
  logic [tcdm_pkg::row_width-1:0]    row_q   [tcdm_pkg::credits];
  logic [tcdm_pkg::data_width-1:0]   wdata_q [tcdm_pkg::credits];
  logic [tcdm_pkg::tag_width-1:0]    tag_q   [tcdm_pkg::credits];
  logic [tcdm_pkg::ptr_width-1:0]    wr_ptr;
  logic [tcdm_pkg::ptr_width-1:0]    rd_ptr;
  logic [tcdm_pkg::credit_width-1:0] count;

  assign head_valid_o = (count != '0);
  assign head_we_o    = we_q[rd_ptr];
  assign head_row_o   = row_q[rd_ptr];
  assign head_wdata_o = wdata_q[rd_ptr];
  assign head_tag_o   = tag_q[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (rreq_valid_i) wr_ptr <= wr_ptr + 1'b1;
      if (pop_i) rd_ptr <= rd_ptr + 1'b1;
      if (rreq_valid_i && !pop_i) begin
        count <= count + 1'b1;
      end else if (!rreq_valid_i && pop_i) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rreq_valid_i) begin
      we_q[wr_ptr]    <= rreq_we_i;
      row_q[wr_ptr]   <= rreq_row_i;
      wdata_q[wr_ptr] <= rreq_wdata_i;
      tag_q[wr_ptr]   <= rreq_tag_i;
    end
  end

endmodule

//--- hdl/tcdm_bank.sv
//----------------------------------------------------------------------
// Local requests win; the FIFO head is served only in idle cycles.
// Writes respond with the word that was overwritten.
//----------------------------------------------------------------------
module tcdm_bank (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            lreq_valid_i,
  input  logic                            lreq_we_i,
  input  logic [tcdm_pkg::row_width-1:0]  lreq_row_i,
  input  logic [tcdm_pkg::data_width-1:0] lreq_wdata_i,
  input  logic [tcdm_pkg::tag_width-1:0]  lreq_tag_i,
  input  logic                            head_valid_i,
  input  logic                            head_we_i,
  input  logic [tcdm_pkg::row_width-1:0]  head_row_i,
  input  logic [tcdm_pkg::data_width-1:0] head_wdata_i,
  input  logic [tcdm_pkg::tag_width-1:0]  head_tag_i,
  output logic                            pop_o,
  output logic                            lresp_valid_o,
  output logic                            lresp_we_o,
  output logic [tcdm_pkg::data_width-1:0] lresp_rdata_o,
  output logic [tcdm_pkg::tag_width-1:0]  lresp_tag_o,
  output logic                            rresp_valid_o,
  output logic                            rresp_we_o,
  output logic [tcdm_pkg::data_width-1:0] rresp_rdata_o,
  output logic [tcdm_pkg::tag_width-1:0]  rresp_tag_o
);

  logic [tcdm_pkg::data_width-1:0] mem [2**tcdm_pkg::row_width];
  logic                            serve_remote;
  logic                            we;
  logic [tcdm_pkg::row_width-1:0]  row;
  logic [tcdm_pkg::data_width-1:0] wdata;
  logic [tcdm_pkg::tag_width-1:0]  tag;
  logic                            we_q;
  logic [tcdm_pkg::data_width-1:0] rdata_q;
  logic [tcdm_pkg::tag_width-1:0]  tag_q;

  assign serve_remote = !lreq_valid_i && head_valid_i;
  assign pop_o        = serve_remote;

  assign we    = lreq_valid_i ? lreq_we_i    : head_we_i;
  assign row   = lreq_valid_i ? lreq_row_i   : head_row_i;
  assign wdata = lreq_valid_i ? lreq_wdata_i : head_wdata_i;
  assign tag   = lreq_valid_i ? lreq_tag_i   : head_tag_i;

  always_ff @(posedge clk_i) begin
    if (lreq_valid_i || serve_remote) begin
      rdata_q <= mem[row];
      we_q    <= we;
      tag_q   <= tag;
      if (we) mem[row] <= wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lresp_valid_o <= 1'b0;
      rresp_valid_o <= 1'b0;
    end else begin
      lresp_valid_o <= lreq_valid_i;
      rresp_valid_o <= serve_remote;
    end
  end

  // One response per cycle, so both ports share the payload
  assign lresp_we_o    = we_q;
  assign lresp_rdata_o = rdata_q;
  assign lresp_tag_o   = tag_q;
  assign rresp_we_o    = we_q;
  assign rresp_rdata_o = rdata_q;
  assign rresp_tag_o   = tag_q;

endmodule

//--- hdl/tcdm_resp_merge.sv
//----------------------------------------------------------------------
// Local responses have priority; remote ones wait in a buffer with a
// slot per credit. Each delivered remote response returns a credit.
//----------------------------------------------------------------------
module tcdm_resp_merge (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            lresp_valid_i,
  input  logic                            lresp_we_i,
  input  logic [tcdm_pkg::data_width-1:0] lresp_rdata_i,
  input  logic [tcdm_pkg::tag_width-1:0]  lresp_tag_i,
  input  logic                            rresp_valid_i,
  input  logic                            rresp_we_i,
  input  logic [tcdm_pkg::data_width-1:0] rresp_rdata_i,
  input  logic [tcdm_pkg::tag_width-1:0]  rresp_tag_i,
  output logic                            resp_valid_o,
  output logic                            resp_we_o,
  output logic [tcdm_pkg::data_width-1:0] resp_rdata_o,
  output logic [tcdm_pkg::tag_width-1:0]  resp_tag_o,
  output logic                            credit_return_o
);

  logic                              we_q    [tcdm_pkg::resp_depth];
  logic [tcdm_pkg::data_width-1:0]   rdata_q [tcdm_pkg::resp_depth];
  logic [tcdm_pkg::tag_width-1:0]    tag_q   [tcdm_pkg::resp_depth];
  logic [tcdm_pkg::ptr_width-1:0]    wr_ptr;
  logic [tcdm_pkg::ptr_width-1:0]    rd_ptr;
  logic [tcdm_pkg::credit_width-1:0] count;
  logic                              deliver;

  assign deliver         = !lresp_valid_i && (count != '0);
  assign credit_return_o = deliver;

  assign resp_valid_o = lresp_valid_i || deliver;
  assign resp_we_o    = lresp_valid_i ? lresp_we_i    : we_q[rd_ptr];
  assign resp_rdata_o = lresp_valid_i ? lresp_rdata_i : rdata_q[rd_ptr];
  assign resp_tag_o   = lresp_valid_i ? lresp_tag_i   : tag_q[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (rresp_valid_i) wr_ptr <= wr_ptr + 1'b1;
      if (deliver) rd_ptr <= rd_ptr + 1'b1;
      if (rresp_valid_i && !deliver) begin
        count <= count + 1'b1;
      end else if (!rresp_valid_i && deliver) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rresp_valid_i) begin
      we_q[wr_ptr]    <= rresp_we_i;
      rdata_q[wr_ptr] <= rresp_rdata_i;
      tag_q[wr_ptr]   <= rresp_tag_i;
    end
  end

endmodule

//--- hdl/tcdm_group.sv
//----------------------------------------------------------------------
// One group: router, own bank, receive FIFO for the other group's
// requests, and the response merger.
//----------------------------------------------------------------------
module tcdm_group (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic [tcdm_pkg::group_width-1:0] group_id_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic                             req_we_i,
  input  tcdm_pkg::tcdm_addr_u             req_addr_i,
  input  logic [tcdm_pkg::data_width-1:0]  req_wdata_i,
  input  logic [tcdm_pkg::tag_width-1:0]   req_tag_i,
  output logic                             resp_valid_o,
  output logic                             resp_we_o,
  output logic [tcdm_pkg::data_width-1:0]  resp_rdata_o,
  output logic [tcdm_pkg::tag_width-1:0]   resp_tag_o,
  output logic                             rreq_valid_o,
  output logic                             rreq_we_o,
  output logic [tcdm_pkg::row_width-1:0]   rreq_row_o,
  output logic [tcdm_pkg::data_width-1:0]  rreq_wdata_o,
  output logic [tcdm_pkg::tag_width-1:0]   rreq_tag_o,
  input  logic                             rreq_valid_i,
  input  logic                             rreq_we_i,
  input  logic [tcdm_pkg::row_width-1:0]   rreq_row_i,
  input  logic [tcdm_pkg::data_width-1:0]  rreq_wdata_i,
  input  logic [tcdm_pkg::tag_width-1:0]   rreq_tag_i,
  output logic                             rresp_valid_o,
  output logic                             rresp_we_o,
  output logic [tcdm_pkg::data_width-1:0]  rresp_rdata_o,
  output logic [tcdm_pkg::tag_width-1:0]   rresp_tag_o,
  input  logic                             rresp_valid_i,
  input  logic                             rresp_we_i,
  input  logic [tcdm_pkg::data_width-1:0]  rresp_rdata_i,
  input  logic [tcdm_pkg::tag_width-1:0]   rresp_tag_i
);

  logic                            lreq_valid;
  logic                            lreq_we;
  logic [tcdm_pkg::row_width-1:0]  lreq_row;
  logic [tcdm_pkg::data_width-1:0] lreq_wdata;
  logic [tcdm_pkg::tag_width-1:0]  lreq_tag;
  logic                            head_valid;
  logic                            head_we;
  logic [tcdm_pkg::row_width-1:0]  head_row;
  logic [tcdm_pkg::data_width-1:0] head_wdata;
  logic [tcdm_pkg::tag_width-1:0]  head_tag;
  logic                            pop;
  logic                            lresp_valid;
  logic                            lresp_we;
  logic [tcdm_pkg::data_width-1:0] lresp_rdata;
  logic [tcdm_pkg::tag_width-1:0]  lresp_tag;
  logic                            credit_return;

  tcdm_router router_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_valid_i     (req_valid_i),
    .req_we_i        (req_we_i),
    .req_addr_i      (req_addr_i),
    .req_wdata_i     (req_wdata_i),
    .req_tag_i       (req_tag_i),
    .group_id_i      (group_id_i),
    .credit_return_i (credit_return),
    .req_ready_o     (req_ready_o),
    .lreq_valid_o    (lreq_valid),
    .lreq_we_o       (lreq_we),
    .lreq_row_o      (lreq_row),
    .lreq_wdata_o    (lreq_wdata),
    .lreq_tag_o      (lreq_tag),
    .rreq_valid_o    (rreq_valid_o),
    .rreq_we_o       (rreq_we_o),
    .rreq_row_o      (rreq_row_o),
    .rreq_wdata_o    (rreq_wdata_o),
    .rreq_tag_o      (rreq_tag_o)
  );

  tcdm_link_rx link_rx_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rreq_valid_i (rreq_valid_i),
    .rreq_we_i    (rreq_we_i),
    .rreq_row_i   (rreq_row_i),
    .rreq_wdata_i (rreq_wdata_i),
    .rreq_tag_i   (rreq_tag_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_we_o    (head_we),
    .head_row_o   (head_row),
    .head_wdata_o (head_wdata),
    .head_tag_o   (head_tag)
  );

  tcdm_bank bank_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lreq_valid_i  (lreq_valid),
    .lreq_we_i     (lreq_we),
    .lreq_row_i    (lreq_row),
    .lreq_wdata_i  (lreq_wdata),
    .lreq_tag_i    (lreq_tag),
    .head_valid_i  (head_valid),
    .head_we_i     (head_we),
    .head_row_i    (head_row),
    .head_wdata_i  (head_wdata),
    .head_tag_i    (head_tag),
    .pop_o         (pop),
    .lresp_valid_o (lresp_valid),
    .lresp_we_o    (lresp_we),
    .lresp_rdata_o (lresp_rdata),
    .lresp_tag_o   (lresp_tag),
    .rresp_valid_o (rresp_valid_o),
    .rresp_we_o    (rresp_we_o),
    .rresp_rdata_o (rresp_rdata_o),
    .rresp_tag_o   (rresp_tag_o)
  );

  tcdm_resp_merge resp_merge_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .lresp_valid_i   (lresp_valid),
    .lresp_we_i      (lresp_we),
    .lresp_rdata_i   (lresp_rdata),
    .lresp_tag_i     (lresp_tag),
    .rresp_valid_i   (rresp_valid_i),
    .rresp_we_i      (rresp_we_i),
    .rresp_rdata_i   (rresp_rdata_i),
    .rresp_tag_i     (rresp_tag_i),
    .resp_valid_o    (resp_valid_o),
    .resp_we_o       (resp_we_o),
    .resp_rdata_o    (resp_rdata_o),
    .resp_tag_o      (resp_tag_o),
    .credit_return_o (credit_return)
  );

endmodule

//--- hdl/tcdm_cluster.sv
//----------------------------------------------------------------------
// Two groups with cross-wired remote links. Responses cannot be
// back-pressured; the requester must always accept them.
//----------------------------------------------------------------------
module tcdm_cluster (
  input  logic                                                      clk_i,
  input  logic                                                      rst_i,
  input  logic [tcdm_pkg::num_groups-1:0]                           req_valid_i,
  output logic [tcdm_pkg::num_groups-1:0]                           req_ready_o,
  input  logic [tcdm_pkg::num_groups-1:0]                           req_we_i,
  input  tcdm_pkg::tcdm_addr_u [tcdm_pkg::num_groups-1:0]            req_addr_i,
  input  logic [tcdm_pkg::num_groups-1:0][tcdm_pkg::data_width-1:0] req_wdata_i,
  input  logic [tcdm_pkg::num_groups-1:0][tcdm_pkg::tag_width-1:0]  req_tag_i,
  output logic [tcdm_pkg::num_groups-1:0]                           resp_valid_o,
  output logic [tcdm_pkg::num_groups-1:0]                           resp_we_o,
  output logic [tcdm_pkg::num_groups-1:0][tcdm_pkg::data_width-1:0] resp_rdata_o,
  output logic [tcdm_pkg::num_groups-1:0][tcdm_pkg::tag_width-1:0]  resp_tag_o
);

  // Indexed by the group that drives the link
  logic [tcdm_pkg::num_groups-1:0]                           rreq_valid;
  logic [tcdm_pkg::num_groups-1:0]                           rreq_we;
  logic [tcdm_pkg::num_groups-1:0][tcdm_pkg::row_width-1:0]  rreq_row;
  logic [tcdm_pkg::num_groups-1:0][tcdm_pkg::data_width-1:0] rreq_wdata;
  logic [tcdm_pkg::num_groups-1:0][tcdm_pkg::tag_width-1:0]  rreq_tag;
  logic [tcdm_pkg::num_groups-1:0]                           rresp_valid;
  logic [tcdm_pkg::num_groups-1:0]                           rresp_we;
  logic [tcdm_pkg::num_groups-1:0][tcdm_pkg::data_width-1:0] rresp_rdata;
  logic [tcdm_pkg::num_groups-1:0][tcdm_pkg::tag_width-1:0]  rresp_tag;

  for (genvar g = 0; g < tcdm_pkg::num_groups; g++) begin : gen_groups
    // Incoming links come from the other group, g ^ 1
    tcdm_group group_inst (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .group_id_i    (tcdm_pkg::group_width'(g)),
      .req_valid_i   (req_valid_i[g]),
      .req_ready_o   (req_ready_o[g]),
      .req_we_i      (req_we_i[g]),
      .req_addr_i    (req_addr_i[g]),
      .req_wdata_i   (req_wdata_i[g]),
      .req_tag_i     (req_tag_i[g]),
      .resp_valid_o  (resp_valid_o[g]),
      .resp_we_o     (resp_we_o[g]),
      .resp_rdata_o  (resp_rdata_o[g]),
      .resp_tag_o    (resp_tag_o[g]),
      .rreq_valid_o  (rreq_valid[g]),
      .rreq_we_o     (rreq_we[g]),
      .rreq_row_o    (rreq_row[g]),
      .rreq_wdata_o  (rreq_wdata[g]),
      .rreq_tag_o    (rreq_tag[g]),
      .rreq_valid_i  (rreq_valid[g ^ 1]),
      .rreq_we_i     (rreq_we[g ^ 1]),
      .rreq_row_i    (rreq_row[g ^ 1]),
      .rreq_wdata_i  (rreq_wdata[g ^ 1]),
      .rreq_tag_i    (rreq_tag[g ^ 1]),
      .rresp_valid_o (rresp_valid[g]),
      .rresp_we_o    (rresp_we[g]),
      .rresp_rdata_o (rresp_rdata[g]),
      .rresp_tag_o   (rresp_tag[g]),
      .rresp_valid_i (rresp_valid[g ^ 1]),
      .rresp_we_i    (rresp_we[g ^ 1]),
      .rresp_rdata_i (rresp_rdata[g ^ 1]),
      .rresp_tag_i   (rresp_tag[g ^ 1])
    );
  end : gen_groups

endmodule

//--- tests/tb_tcdm_cluster.sv
//----------------------------------------------------------------------
// Port p only writes rows p*32 to p*32+31 of either bank, so the table
// stays exact. Barrier steps drain all traffic before ports share rows.
//----------------------------------------------------------------------
module tb_tcdm_cluster;

  localparam int period  = 40;
  localparam int barrier = 2;

  typedef struct {
    int          port;
    logic        we;
    logic [6:0]  addr;
    logic [31:0] wdata;
    logic [3:0]  tag;
    logic [31:0] exp_rdata;
    bit          exp_known;
  } step_t;

  logic                                  clk_i = 1'b0;
  logic                                  rst_i;
  logic [1:0]                            req_valid_i;
  logic [1:0]                            req_ready_o;
  logic [1:0]                            req_we_i;
  tcdm_pkg::tcdm_addr_u [1:0]            req_addr_i;
  logic [1:0][tcdm_pkg::data_width-1:0]  req_wdata_i;
  logic [1:0][tcdm_pkg::tag_width-1:0]   req_tag_i;
  logic [1:0]                            resp_valid_o;
  logic [1:0]                            resp_we_o;
  logic [1:0][tcdm_pkg::data_width-1:0]  resp_rdata_o;
  logic [1:0][tcdm_pkg::tag_width-1:0]   resp_tag_o;

  step_t       steps [$];
  logic [31:0] ref_mem [128];
  bit          ref_known [128];
  logic [3:0]  next_tag [2];
  bit          pend_valid [2][16];
  int          pend_idx [2][16];
  time         pend_time [2][16];
  int          pend_cnt [2];
  int          bar_cnt [2];
  int          acc_cnt [2];
  int          first_stall_at;
  int          resume_busy;

  tcdm_cluster tcdm_cluster_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_we_i     (req_we_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_tag_i    (req_tag_i),
    .resp_valid_o (resp_valid_o),
    .resp_we_o    (resp_we_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_tag_o   (resp_tag_o)
  );

  always #(period / 2) clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Expected data is the old word; a write then updates the model
  function automatic void add_step(input int p, input logic we, input logic [6:0] addr);
    step_t s;
    s.port      = p;
    s.we        = we;
    s.addr      = addr;
    s.wdata     = $urandom;
    s.tag       = next_tag[p];
    s.exp_rdata = ref_mem[addr];
    s.exp_known = ref_known[addr];
    next_tag[p] = next_tag[p] + 4'd1;
    if (we) begin
      ref_mem[addr]   = s.wdata;
      ref_known[addr] = 1'b1;
    end
    steps.push_back(s);
  endfunction

  function automatic void add_barrier();
    step_t s;
    s = '{default: '0};
    s.port = barrier;
    steps.push_back(s);
  endfunction

  function automatic void build_table();
    int         k;
    int         p;
    logic       grp;
    logic [5:0] row;
    // Local write then read on each port
    add_step(0, 1'b1, 7'h03);
    add_step(0, 1'b0, 7'h03);
    add_step(1, 1'b1, 7'h63);
    add_step(1, 1'b0, 7'h63);
    add_barrier();
    // Remote write and read from port 0, then port 1 reads it locally
    add_step(0, 1'b1, 7'h45);
    add_step(0, 1'b0, 7'h45);
    add_barrier();
    add_step(1, 1'b0, 7'h45);
    add_barrier();
    // Five remote requests against eight local ones on bank 1
    for (k = 0; k < 8; k++) begin
      if (k < 5) add_step(0, 1'b1, 7'(8'h48 + k));
      add_step(1, 1'b1, 7'(8'h68 + k));
    end
    add_barrier();
    // Mixed random traffic
    for (k = 0; k < 40; k++) begin
      p   = int'($urandom % 2);
      grp = 1'($urandom % 2);
      row = 6'(p * 32 + int'($urandom % 32));
      add_step(p, 1'($urandom % 2), {grp, row});
    end
    add_barrier();
  endfunction

  task automatic drive_port(input int p);
    int i;
    bit taken;
    bit is_local;
    for (i = 0; i < steps.size(); i++) begin
      if (steps[i].port == barrier) begin
        bar_cnt[p]++;
        // Both drivers poll at the same instant and leave together
        do begin
          @(posedge clk_i);
          #1;
        end while (bar_cnt[0] != bar_cnt[1] || pend_cnt[0] != 0 || pend_cnt[1] != 0);
        acc_cnt[p] = 0;
        #1;
      end else if (steps[i].port == p) begin
        is_local           = (steps[i].addr[6] == p[0]);
        req_valid_i[p]     = 1'b1;
        req_we_i[p]        = steps[i].we;
        req_addr_i[p].flat = steps[i].addr;
        req_wdata_i[p]     = steps[i].wdata;
        req_tag_i[p]       = steps[i].tag;
        taken              = 1'b0;
        while (!taken) begin
          @(posedge clk_i);
          if (req_ready_o[p]) begin
            taken = 1'b1;
            if (pend_valid[p][steps[i].tag]) begin
              fail_run($sformatf("Port %0d reused tag %0h while it was outstanding",
                                 p, steps[i].tag));
            end
            // First remote accept after the stall, port 1 must be idle by now
            if (p == 0 && first_stall_at >= 0 && resume_busy < 0) begin
              resume_busy = int'(req_valid_i[1]);
            end
            pend_valid[p][steps[i].tag] = 1'b1;
            pend_idx[p][steps[i].tag]   = i;
            pend_time[p][steps[i].tag]  = $time;
            pend_cnt[p]++;
            acc_cnt[p]++;
          end else if (is_local) begin
            fail_run($sformatf("Port %0d was not ready for a local request", p));
          end else if (p == 0 && first_stall_at < 0) begin
            first_stall_at = acc_cnt[0];
          end
          #2;
        end
        req_valid_i[p] = 1'b0;
      end
    end
  endtask

  task automatic monitor_responses();
    int         p;
    int         idx;
    logic [3:0] tg;
    forever begin
      @(posedge clk_i);
      for (p = 0; p < 2; p++) begin
        if (resp_valid_o[p]) begin
          tg = resp_tag_o[p];
          if (!pend_valid[p][tg]) begin
            fail_run($sformatf("Port %0d got a response with tag %0h and no request", p, tg));
          end
          idx = pend_idx[p][tg];
          check_value($sformatf("resp_we_o[%0d]", p), 32'(resp_we_o[p]), 32'(steps[idx].we));
          if (steps[idx].exp_known) begin
            check_value($sformatf("resp_rdata_o[%0d]", p), resp_rdata_o[p],
                        steps[idx].exp_rdata);
          end
          // Local responses come exactly one cycle after acceptance
          if (steps[idx].addr[6] == p[0]) begin
            check_value($sformatf("local latency port %0d", p),
                        32'(($time - pend_time[p][tg]) / period), 32'd1);
          end
          pend_valid[p][tg] = 1'b0;
          pend_cnt[p]--;
        end
      end
    end
  endtask

  initial begin
    int limit;
    void'($urandom(89));
    rst_i          = 1'b1;
    req_valid_i    = '0;
    req_we_i       = '0;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    req_tag_i      = '0;
    next_tag[0]    = '0;
    next_tag[1]    = '0;
    first_stall_at = -1;
    resume_busy    = -1;
    build_table();
    limit = (steps.size() * 20 + 16) * period;
    fork
      begin
        #(limit);
        fail_run("Timeout: the stimulus table did not finish in time");
      end
    join_none
    repeat (8) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    // Idle after reset
    repeat (3) begin
      @(posedge clk_i);
      check_value("resp_valid_o", 32'(resp_valid_o), 32'd0);
      check_value("req_ready_o", 32'(req_ready_o), 32'd3);
    end
    #2;
    fork
      monitor_responses();
    join_none
    fork
      drive_port(0);
      drive_port(1);
    join
    check_value("remote accepts before stall", 32'(first_stall_at), 32'(tcdm_pkg::credits));
    check_value("port 1 valid at remote resume", 32'(resume_busy), 32'd0);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- verilog.f
hdl/tcdm_pkg.sv
hdl/tcdm_router.sv
hdl/tcdm_link_rx.sv
hdl/tcdm_bank.sv
hdl/tcdm_resp_merge.sv
hdl/tcdm_group.sv
hdl/tcdm_cluster.sv
tests/tb_tcdm_cluster.sv

//--- Makefile
# Verilator build and run for the two-group TCDM cluster

VERILATOR ?= verilator
TOP       ?= tb_tcdm_cluster
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
